// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := instr_fetch_tb
FILELIST  := instr_fetch_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== instr_fetch_top.f ====
source/riscv_isa_pkg.sv
source/fetch_pkg.sv
source/prefetch_requester.sv
source/fetch_fifo.sv
source/compressed_decoder.sv
source/instr_aligner.sv
source/instr_fetch_top.sv
verification/instr_fetch_tb.sv

// ==== source/compressed_decoder.sv ====
// compressed instruction decoder
// expands the 16-bit parcels of the core's compressed variant to RV32
// and raises illegal on reserved encodings and forbidden zero registers
// 32-bit words pass through unchanged

`timescale 1ns/1ps

module compressed_decoder
  import riscv_isa_pkg::*;
(
  input  instr_t instr_i,
  output instr_t instr_o,
  output logic   is_compressed_o,
  output logic   illegal_instr_o
);

  cinstr_t     c;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  rs1p;
  logic [4:0]  rs2p;
  logic [4:0]  rs3p;
  logic [11:0] imm6;
  logic        imm6_zero;

  assign c    = instr_i[15:0];
  // full register fields
  assign rd   = c[11:7];
  assign rs2  = c[6:2];
  // 3-bit register fields map onto x8..x15
  assign rs1p = {2'b01, c[9:7]};
  assign rs2p = {2'b01, c[4:2]};
  assign rs3p = {2'b01, c[12:10]};
  // sign-extended 6-bit immediate
  assign imm6      = {{6{c[12]}}, c[12], c[6:2]};
  assign imm6_zero = ({c[12], c[6:2]} == 6'b0);

  always_comb begin
    instr_o         = '0;
    is_compressed_o = 1'b1;
    illegal_instr_o = 1'b0;

    unique case (c[1:0])
      ////////////////////////////////////////
      // quadrant 0
      2'b00: begin
        unique case (c[15:13])
          // c.mv when bit 12 is low, c.add when high
          3'b000: begin
            instr_o         = {7'b0, rs2, (c[12] ? rd : 5'b0), 3'b000, rd, OPCODE_OP};
            illegal_instr_o = (rd == 5'b0);
          end
          // c.srai
          3'b001: begin
            instr_o         = {7'b0100000, rs2, rd, 3'b101, rd, OPCODE_OPIMM};
            illegal_instr_o = c[12] || (rs2 == 5'b0) || (rd == 5'b0);
          end
          // c.sw
          3'b010: instr_o = {5'b0, c[5], c[12], rs2p, rs1p, 3'b010, c[11:10], c[6], 2'b00,
                             OPCODE_STORE};
          3'b011: begin
            unique case ({c[12:10], c[6:5]})
              // c.xor
              5'b00000: instr_o = {7'b0, rs2p, rs1p, 3'b100, rs1p, OPCODE_OP};
              // c.srl
              5'b00101: instr_o = {7'b0, rs2p, rs1p, 3'b101, rs1p, OPCODE_OP};
              // c.sllr uses rs2' for every operand
              5'b01100: instr_o = {7'b0, rs2p, rs2p, 3'b001, rs2p, OPCODE_OP};
              // c.sltur writes rs2'
              5'b01111: instr_o = {7'b0, rs2p, rs1p, 3'b011, rs2p, OPCODE_OP};
              default:  illegal_instr_o = 1'b1;
            endcase
          end
          // c.sub
          3'b100: begin
            instr_o         = {7'b0100000, rs2, rd, 3'b000, rd, OPCODE_OP};
            illegal_instr_o = c[12] || (rs2 == 5'b0) || (rd == 5'b0);
          end
          // c.add3 c.sub3 c.or3 c.and3 picked by bits 6:5
          3'b101: instr_o = {1'b0, (c[6:5] == 2'b01), 5'b0, rs2p, rs1p,
                             (c[6] ? {2'b11, c[5]} : 3'b000), rs3p, OPCODE_OP};
          // c.lw
          3'b110: instr_o = {5'b0, c[5], c[12:10], c[6], 2'b00, rs1p, 3'b010, rs2p,
                             OPCODE_LOAD};
          default: illegal_instr_o = 1'b1;
        endcase
      end

      ////////////////////////////////////////
      // quadrant 1
      2'b01: begin
        unique case (c[15:13])
          // c.slli and c.srli differ in bit 13 only
          3'b000, 3'b001: begin
            instr_o         = {7'b0, rs2, rd, c[13], 2'b01, rd, OPCODE_OPIMM};
            illegal_instr_o = (rd == 5'b0) || c[12] || (rs2 == 5'b0);
          end
          // c.swsp
          3'b010: instr_o = {4'b0, c[8:7], c[12], rs2, 5'h02, 3'b010, c[11:9], 2'b00,
                             OPCODE_STORE};
          // c.addin c.xorin c.orin c.andin
          3'b100: begin
            instr_o         = {{9{c[12]}}, c[12:10], rs1p, {c[6] | c[5], c[6], c[6] & c[5]},
                               rs2p, OPCODE_OPIMM};
            illegal_instr_o = (c[12:10] == 3'b0);
          end
          // c.addi4spn
          3'b101: instr_o = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'h02, 3'b000, rs2p,
                             OPCODE_OPIMM};
          // c.lwsp needs a real destination
          3'b110: begin
            instr_o         = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'h02, 3'b010, rd,
                               OPCODE_LOAD};
            illegal_instr_o = (rd == 5'b0);
          end
          default: illegal_instr_o = 1'b1;
        endcase
      end

      ////////////////////////////////////////
      // quadrant 2
      2'b10: begin
        unique case (c[15:13])
          // c.j and c.jal, bit 13 selects the link register
          3'b000, 3'b001: instr_o = {c[12], c[11:7], c[2], c[6:3], {9{c[12]}}, 4'b0, c[13],
                                     OPCODE_JAL};
          // c.beqz and c.bnez
          3'b010, 3'b011: instr_o = {{3{c[12]}}, c[12:10], c[2], 5'b0, rs1p, 2'b00, c[13],
                                     c[6:3], c[12], OPCODE_BRANCH};
          // c.jr with a zero immediate, c.li otherwise
          3'b100: begin
            if (imm6_zero) begin
              instr_o = {12'b0, rd, 3'b000, 5'b0, OPCODE_JALR};
            end else begin
              instr_o = {imm6, 5'b0, 3'b000, rd, OPCODE_OPIMM};
            end
            illegal_instr_o = (rd == 5'b0);
          end
          // c.jalr with a zero immediate, c.lui otherwise
          3'b101: begin
            if (imm6_zero) begin
              instr_o = {12'b0, rd, 3'b000, 5'b00001, OPCODE_JALR};
            end else begin
              instr_o = {{15{c[12]}}, rs2, rd, OPCODE_LUI};
            end
            illegal_instr_o = (rd == 5'b0);
          end
          // c.addi16sp when rd is zero, c.addi otherwise
          3'b110: begin
            if (rd == 5'b0) begin
              instr_o = {{3{c[12]}}, c[4:2], c[5], c[6], 4'b0, 5'h02, 3'b000, 5'h02,
                         OPCODE_OPIMM};
            end else begin
              instr_o = {imm6, rd, 3'b000, rd, OPCODE_OPIMM};
            end
            illegal_instr_o = imm6_zero;
          end
          // c.andi
          default: begin
            instr_o         = {imm6, rd, 3'b111, rd, OPCODE_OPIMM};
            illegal_instr_o = (rd == 5'b0);
          end
        endcase
      end

      // already a full 32-bit instruction
      default: begin
        instr_o         = instr_i;
        is_compressed_o = 1'b0;
      end
    endcase
  end

endmodule

// ==== source/fetch_fifo.sv ====
// fetch FIFO
// circular buffer of tagged instruction words between the requester
// and the aligner, flushed in one cycle on a redirect

`timescale 1ns/1ps

module fetch_fifo
  import fetch_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4,
  localparam int unsigned AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1,
  localparam int unsigned CW = $clog2(FIFO_DEPTH + 1)
) (
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic          flush_i,
  input  logic          push_i,
  input  fifo_entry_t   entry_i,
  input  logic          pop_i,
  output fifo_entry_t   head_o,
  output logic          empty_o,
  output logic [CW-1:0] count_o
);

  fifo_entry_t   mem_q [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr_q;
  logic [AW-1:0] rd_ptr_q;
  logic          full;
  logic          do_push;
  logic          do_pop;

  assign full    = (count_o == CW'(FIFO_DEPTH));
  assign empty_o = (count_o == '0);
  assign head_o  = mem_q[rd_ptr_q];

  // flush wins over both ports
  assign do_push = push_i && !flush_i;
  assign do_pop  = pop_i && !flush_i;

  ////////////////////////////////////////
  // pointers and occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o  <= '0;
    end else begin
      // power-of-two depth lets the pointers wrap on their own
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_o <= count_o + CW'(do_push) - CW'(do_pop);
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

  // requester credits keep the buffer from overflowing
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    do_push |-> !full);

  // aligner only pops a word it has seen
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
    pop_i |-> !empty_o);

endmodule

// ==== source/fetch_pkg.sv ====
// fetch front end types
// byte addresses, fetch FIFO entries and the instruction handed to the core

package fetch_pkg;

  import riscv_isa_pkg::*;

  // byte address
  typedef logic [31:0] addr_t;

  // one fetched memory word tagged with its word address
  typedef struct packed {
    addr_t  addr;
    instr_t data;
  } fifo_entry_t;

  // instruction presented to the core
  typedef struct packed {
    addr_t  pc;
    // expanded to RV32 when it came from a 16-bit parcel
    instr_t instr;
    logic   is_compressed;
    logic   illegal;
  } fetch_out_t;

endpackage

// ==== source/instr_aligner.sv ====
// instruction aligner
// walks the fetched words one halfword at a time, joins 32-bit
// instructions that straddle two words, expands compressed parcels
// and holds the result in the output register until the core takes it

`timescale 1ns/1ps

module instr_aligner
  import riscv_isa_pkg::*, fetch_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n_i,
  input  logic        branch_i,
  input  addr_t       branch_addr_i,
  input  fifo_entry_t head_i,
  input  logic        empty_i,
  input  logic        instr_ready_i,
  output logic        pop_o,
  output fetch_out_t  fetch_o,
  output logic        instr_valid_o
);

  // which halfword of the head word comes next
  typedef enum logic [1:0] {
    ALIGN_LOW,
    ALIGN_HIGH,
    ALIGN_SPLIT
  } align_state_e;

  align_state_e state_q;
  align_state_e state_d;
  addr_t        pc_q;
  // low half of a 32-bit instruction that began in the previous word
  cinstr_t      carry_q;
  instr_t       dec_in;
  instr_t       dec_instr;
  logic         dec_c;
  logic         dec_ill;
  logic         valid_q;
  logic         slot_free;
  logic         advance;
  logic         emit;
  logic         take_carry;

  // redirect drops the held instruction in the same cycle
  assign instr_valid_o = valid_q && !branch_i;

  assign slot_free = !valid_q || instr_ready_i;
  assign advance   = !branch_i && slot_free && !empty_i;

  // candidate instruction for the current position
  always_comb begin
    unique case (state_q)
      ALIGN_HIGH:  dec_in = {16'h0000, head_i.data[31:16]};
      ALIGN_SPLIT: dec_in = {head_i.data[15:0], carry_q};
      default:     dec_in = head_i.data;
    endcase
  end

  compressed_decoder i_compressed_decoder (
    .instr_i         (dec_in),
    .instr_o         (dec_instr),
    .is_compressed_o (dec_c),
    .illegal_instr_o (dec_ill)
  );

  // an upper halfword starting a 32-bit instruction waits for the next word
  assign take_carry = advance && (state_q == ALIGN_HIGH) && !dec_c;
  assign emit       = advance && ((state_q != ALIGN_HIGH) || dec_c);

  // word is done once its upper halfword has been used
  assign pop_o = advance && (((state_q == ALIGN_LOW) && !dec_c) || (state_q == ALIGN_HIGH));

  ////////////////////////////////////////
  // halfword position FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    if (advance) begin
      unique case (state_q)
        ALIGN_LOW:  state_d = dec_c ? ALIGN_HIGH : ALIGN_LOW;
        ALIGN_HIGH: state_d = dec_c ? ALIGN_LOW : ALIGN_SPLIT;
        default:    state_d = ALIGN_HIGH;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ALIGN_LOW;
      pc_q    <= '0;
      valid_q <= 1'b0;
    end else if (branch_i) begin
      // odd halfword target skips the low half of the first word
      state_q <= branch_addr_i[1] ? ALIGN_HIGH : ALIGN_LOW;
      pc_q    <= branch_addr_i;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (emit) begin
        pc_q    <= pc_q + (dec_c ? 32'd2 : 32'd4);
        valid_q <= 1'b1;
      end else if (instr_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  // output and carry registers
  always_ff @(posedge clk) begin
    if (take_carry) begin
      carry_q <= head_i.data[31:16];
    end
    if (emit) begin
      fetch_o <= '{pc: pc_q, instr: dec_instr, is_compressed: dec_c, illegal: dec_ill};
    end
  end

  // word at the head must be the one the PC points into
  a_head_matches_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
    (!branch_i && !empty_i) |->
      (head_i.addr[31:2] == pc_q[31:2] + 30'(state_q == ALIGN_SPLIT)));

endmodule

// ==== source/instr_fetch_top.sv ====
// instruction fetch front end
// prefetch requester, fetch FIFO and aligner between instruction
// memory and the core, restarted by a redirect from the core

`timescale 1ns/1ps

module instr_fetch_top
  import riscv_isa_pkg::*, fetch_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst_n_i,
  // redirect from the core
  input  logic       branch_i,
  input  addr_t      branch_addr_i,
  // instruction memory
  input  logic       mem_rvalid_i,
  input  instr_t     mem_rdata_i,
  output logic       mem_req_o,
  output addr_t      mem_addr_o,
  // instruction to the core
  input  logic       instr_ready_i,
  output fetch_out_t fetch_o,
  output logic       instr_valid_o
);

  localparam int unsigned CW = $clog2(FIFO_DEPTH + 1);

  logic          fifo_push;
  logic          fifo_pop;
  logic          fifo_empty;
  logic [CW-1:0] fifo_count;
  fifo_entry_t   fifo_entry;
  fifo_entry_t   fifo_head;

  prefetch_requester #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_prefetch_requester (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .fifo_count_i  (fifo_count),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .fifo_push_o   (fifo_push),
    .fifo_entry_o  (fifo_entry)
  );

  // redirect empties the buffer
  fetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_fetch_fifo (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .flush_i (branch_i),
    .push_i  (fifo_push),
    .entry_i (fifo_entry),
    .pop_i   (fifo_pop),
    .head_o  (fifo_head),
    .empty_o (fifo_empty),
    .count_o (fifo_count)
  );

  instr_aligner i_instr_aligner (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .head_i        (fifo_head),
    .empty_i       (fifo_empty),
    .instr_ready_i (instr_ready_i),
    .pop_o         (fifo_pop),
    .fetch_o       (fetch_o),
    .instr_valid_o (instr_valid_o)
  );

endmodule

// ==== source/prefetch_requester.sv ====
// prefetch requester
// issues word reads to instruction memory as long as credits remain
// and tags every response with its address before pushing it to the FIFO
// after a redirect the responses of stale reads are dropped

`timescale 1ns/1ps

module prefetch_requester
  import riscv_isa_pkg::*, fetch_pkg::*;
#(
  parameter int unsigned FIFO_DEPTH = 4,
  localparam int unsigned AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1,
  localparam int unsigned CW = $clog2(FIFO_DEPTH + 1)
) (
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic          branch_i,
  input  addr_t         branch_addr_i,
  input  logic          mem_rvalid_i,
  input  instr_t        mem_rdata_i,
  input  logic [CW-1:0] fifo_count_i,
  output logic          mem_req_o,
  output addr_t         mem_addr_o,
  output logic          fifo_push_o,
  output fifo_entry_t   fifo_entry_o
);

  addr_t         next_addr_q;
  addr_t         req_addr;
  // addresses of outstanding reads in request order
  addr_t         tag_q [FIFO_DEPTH];
  logic [AW-1:0] tag_wr_q;
  logic [AW-1:0] tag_rd_q;
  logic [CW-1:0] out_cnt_q;
  logic [CW-1:0] out_cnt_d;
  logic [CW-1:0] drop_cnt_q;
  logic [CW:0]   used;
  logic          req_d;

  // redirect target word overrides the sequential address
  assign req_addr = branch_i ? {branch_addr_i[31:2], 2'b00} : next_addr_q;

  // reads in flight, the strobe on the bus now, and words already buffered
  assign used  = {1'b0, out_cnt_q} + {1'b0, fifo_count_i} + {{CW{1'b0}}, mem_req_o};
  assign req_d = used < (CW + 1)'(FIFO_DEPTH);

  assign out_cnt_d = out_cnt_q + CW'(mem_req_o) - CW'(mem_rvalid_i);

  // responses in the redirect cycle belong to the old stream as well
  assign fifo_push_o  = mem_rvalid_i && (drop_cnt_q == '0) && !branch_i;
  assign fifo_entry_o = '{addr: tag_q[tag_rd_q], data: mem_rdata_i};

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_req_o   <= 1'b0;
      next_addr_q <= '0;
      out_cnt_q   <= '0;
      drop_cnt_q  <= '0;
      tag_wr_q    <= '0;
      tag_rd_q    <= '0;
    end else begin
      mem_req_o <= req_d;
      out_cnt_q <= out_cnt_d;
      if (req_d) begin
        next_addr_q <= req_addr + 32'd4;
      end else if (branch_i) begin
        next_addr_q <= req_addr;
      end
      if (mem_req_o) begin
        tag_wr_q <= tag_wr_q + 1'b1;
      end
      if (mem_rvalid_i) begin
        tag_rd_q <= tag_rd_q + 1'b1;
      end
      // every read still open at a redirect is stale
      if (branch_i) begin
        drop_cnt_q <= out_cnt_d;
      end else if (mem_rvalid_i && (drop_cnt_q != '0)) begin
        drop_cnt_q <= drop_cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_d) begin
      mem_addr_o <= req_addr;
    end
    if (mem_req_o) begin
      tag_q[tag_wr_q] <= mem_addr_o;
    end
  end

  // reads in flight plus buffered words stay within the FIFO size
  a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n_i)
    used <= (CW + 1)'(FIFO_DEPTH));

  // memory only answers reads that were issued
  a_no_orphan_rvalid: assert property (@(posedge clk) disable iff (!rst_n_i)
    mem_rvalid_i |-> (out_cnt_q != '0));

endmodule

// ==== source/riscv_isa_pkg.sv ====
// RV32 instruction set definitions
// major opcodes and word types shared by the compressed decoder
// and the testbench reference model

package riscv_isa_pkg;

  // full 32-bit instruction word
  typedef logic [31:0] instr_t;

  // one 16-bit compressed parcel
  typedef logic [15:0] cinstr_t;

  // major opcode field, bits 6:0
  typedef logic [6:0] opcode_t;

  ////////////////////////////////////////
  // major opcodes used by the expansion
  ////////////////////////////////////////

  // register-register alu ops
  localparam opcode_t OPCODE_OP     = 7'h33;
  // register-immediate alu ops
  localparam opcode_t OPCODE_OPIMM  = 7'h13;
  // loads
  localparam opcode_t OPCODE_LOAD   = 7'h03;
  // stores
  localparam opcode_t OPCODE_STORE  = 7'h23;
  // jump and link
  localparam opcode_t OPCODE_JAL    = 7'h6f;
  // jump and link register
  localparam opcode_t OPCODE_JALR   = 7'h67;
  // conditional branches
  localparam opcode_t OPCODE_BRANCH = 7'h63;
  // load upper immediate
  localparam opcode_t OPCODE_LUI    = 7'h37;

endpackage

// ==== verification/instr_fetch_tb.sv ====
// testbench for the instruction fetch front end
// memory model with random in-order latency, core model with a checked
// output queue, and directed tests for expansion, alignment and redirect

`timescale 1ns/1ps

module instr_fetch_tb
  import riscv_isa_pkg::*, fetch_pkg::*;
;

  logic       clk;
  logic       rst_n_i;
  logic       branch_i;
  addr_t      branch_addr_i;
  logic       mem_rvalid_i;
  instr_t     mem_rdata_i;
  logic       mem_req_o;
  addr_t      mem_addr_o;
  logic       instr_ready_i;
  fetch_out_t fetch_o;
  logic       instr_valid_o;

  instr_t      imem [128];
  fetch_out_t  exp_q [$];
  logic        mask_q [$];
  addr_t       rd_addr_q [$];
  int          due_q [$];
  logic [31:0] lfsr_q = 32'd98834;
  int          cyc = 0;
  int          last_due = 0;
  int          due;
  int          outstanding = 0;
  int          errors = 0;
  int          checks = 0;
  logic        hold_q = 1'b0;
  fetch_out_t  held;
  fetch_out_t  exp_item;
  addr_t       req_exp = '0;

  instr_fetch_top #(
    .FIFO_DEPTH (4)
  ) i_instr_fetch_top (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .instr_ready_i (instr_ready_i),
    .fetch_o       (fetch_o),
    .instr_valid_o (instr_valid_o)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // fibonacci LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic check_value(input logic [65:0] got, input logic [65:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic expect_instr(input addr_t pc, input instr_t instr, input logic c,
                              input logic ill, input logic cmp_instr);
    exp_q.push_back('{pc: pc, instr: instr, is_compressed: c, illegal: ill});
    mask_q.push_back(cmp_instr);
  endtask

  // wait until the core model has taken every expected instruction
  task automatic wait_drain(input string what);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 200) begin
      next_cycle();
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("ERROR: timeout after 200 cycles waiting for %s", what);
      exp_q.delete();
      mask_q.delete();
    end
  endtask

  task automatic redirect(input addr_t target);
    branch_i      = 1'b1;
    branch_addr_i = target;
    next_cycle();
    branch_i      = 1'b0;
  endtask

  // 32-bit addi rd, rd, imm
  function automatic instr_t mk_addi(input logic [4:0] rd, input logic [11:0] imm);
    return {imm, rd, 3'b000, rd, OPCODE_OPIMM};
  endfunction

  ////////////////////////////////////////
  // compressed encodings and their RV32 forms
  ////////////////////////////////////////

  function automatic cinstr_t enc_caddi(input logic [4:0] rd, input logic [5:0] imm);
    return {3'b110, imm[5], rd, imm[4:0], 2'b10};
  endfunction

  function automatic cinstr_t enc_cli(input logic [4:0] rd, input logic [5:0] imm);
    return {3'b100, imm[5], rd, imm[4:0], 2'b10};
  endfunction

  // off is the byte offset, word aligned
  function automatic cinstr_t enc_clwsp(input logic [4:0] rd, input logic [7:0] off);
    return {3'b110, off[5], rd, off[4:2], off[7:6], 2'b01};
  endfunction

  function automatic cinstr_t enc_cj(input logic [11:0] off);
    return {3'b000, off[11], off[10:6], off[4:1], off[5], 2'b10};
  endfunction

  function automatic instr_t exp_caddi(input logic [4:0] rd, input logic [5:0] imm);
    return {{6{imm[5]}}, imm, rd, 3'b000, rd, OPCODE_OPIMM};
  endfunction

  function automatic instr_t exp_cli(input logic [4:0] rd, input logic [5:0] imm);
    return {{6{imm[5]}}, imm, 5'd0, 3'b000, rd, OPCODE_OPIMM};
  endfunction

  // lw rd, off(sp)
  function automatic instr_t exp_clwsp(input logic [4:0] rd, input logic [7:0] off);
    return {4'b0, off, 5'd2, 3'b010, rd, OPCODE_LOAD};
  endfunction

  // jal x0 with the sign-extended offset in J-type order
  function automatic instr_t exp_cj(input logic [11:0] off);
    return {off[11], off[10:1], off[11], {8{off[11]}}, 5'd0, OPCODE_JAL};
  endfunction

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  always @(posedge clk) begin
    cyc++;
    if (rst_n_i && mem_req_o) begin
      // sequential word reads
      check_value(66'(mem_addr_o), 66'(req_exp), "mem_addr_o");
      req_exp = req_exp + 32'd4;
      due = cyc + 1 + int'(lfsr_bits(2));
      // in order, one response per cycle
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      rd_addr_q.push_back(mem_addr_o);
      due_q.push_back(due);
    end
    // reads after a redirect restart at the word that holds the target
    if (rst_n_i && branch_i) begin
      req_exp = branch_addr_i & ~32'd3;
    end
    #1;
    if (due_q.size() != 0 && due_q[0] <= cyc) begin
      mem_rvalid_i = 1'b1;
      mem_rdata_i  = imem[rd_addr_q[0][8:2]];
      void'(rd_addr_q.pop_front());
      void'(due_q.pop_front());
    end else begin
      mem_rvalid_i = 1'b0;
    end
  end

  ////////////////////////////////////////
  // core model and bus monitor
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n_i) begin
      outstanding = outstanding + int'(mem_req_o) - int'(mem_rvalid_i);
      check_value(66'(outstanding > 4), 66'd0, "reads outstanding above 4");
      // the held instruction is dropped in the redirect cycle
      if (branch_i) begin
        check_value(66'(instr_valid_o), 66'd0, "valid during redirect");
      end
      // a stalled instruction must stay put
      if (hold_q && !branch_i) begin
        check_value(66'(instr_valid_o), 66'd1, "valid dropped while stalled");
        check_value(fetch_o, held, "output changed while stalled");
      end
      hold_q = instr_valid_o && !instr_ready_i;
      held   = fetch_o;
      if (instr_valid_o && instr_ready_i && exp_q.size() != 0) begin
        exp_item = exp_q.pop_front();
        check_value(66'(fetch_o.pc), 66'(exp_item.pc), "pc");
        if (mask_q.pop_front()) begin
          check_value(66'(fetch_o.instr), 66'(exp_item.instr), "instr");
        end
        check_value(66'(fetch_o.is_compressed), 66'(exp_item.is_compressed),
                    "is_compressed");
        check_value(66'(fetch_o.illegal), 66'(exp_item.illegal), "illegal");
      end
    end
  end

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_plain_stream();
    for (int k = 0; k < 4; k++) begin
      imem[k] = mk_addi(5'(k + 1), 12'(16 * k + 7));
      expect_instr(addr_t'(4 * k), imem[k], 1'b0, 1'b0, 1'b1);
    end
    rst_n_i = 1'b1;
    wait_drain("plain 32-bit stream");
  endtask

  task automatic test_compressed();
    imem[16] = {enc_clwsp(5'd9, 8'h24), enc_caddi(5'd5, 6'd3)};
    imem[17] = {enc_cli(5'd12, 6'h3b), enc_cj(12'hff8)};
    imem[18] = {enc_cli(5'd3, 6'd17), enc_caddi(5'd8, 6'h3f)};
    redirect(32'h40);
    expect_instr(32'h40, exp_caddi(5'd5, 6'd3), 1'b1, 1'b0, 1'b1);
    expect_instr(32'h42, exp_clwsp(5'd9, 8'h24), 1'b1, 1'b0, 1'b1);
    expect_instr(32'h44, exp_cj(12'hff8), 1'b1, 1'b0, 1'b1);
    expect_instr(32'h46, exp_cli(5'd12, 6'h3b), 1'b1, 1'b0, 1'b1);
    expect_instr(32'h48, exp_caddi(5'd8, 6'h3f), 1'b1, 1'b0, 1'b1);
    expect_instr(32'h4a, exp_cli(5'd3, 6'd17), 1'b1, 1'b0, 1'b1);
    wait_drain("compressed expansion");
  endtask

  // every 32-bit instruction here straddles two words
  task automatic test_mixed_alignment(input logic do_redirect);
    instr_t a;
    instr_t b;
    instr_t c;
    a = mk_addi(5'd10, 12'h123);
    b = mk_addi(5'd11, 12'h456);
    c = mk_addi(5'd13, 12'h789);
    imem[24] = {a[15:0], enc_cli(5'd7, 6'd5)};
    imem[25] = {b[15:0], a[31:16]};
    imem[26] = {c[15:0], b[31:16]};
    imem[27] = {enc_cli(5'd14, 6'd9), c[31:16]};
    if (do_redirect) begin
      redirect(32'h60);
      expect_instr(32'h60, exp_cli(5'd7, 6'd5), 1'b1, 1'b0, 1'b1);
      expect_instr(32'h62, a, 1'b0, 1'b0, 1'b1);
    end
    expect_instr(32'h66, b, 1'b0, 1'b0, 1'b1);
    expect_instr(32'h6a, c, 1'b0, 1'b0, 1'b1);
    expect_instr(32'h6e, exp_cli(5'd14, 6'd9), 1'b1, 1'b0, 1'b1);
  endtask

  task automatic test_illegal();
    imem[32] = {16'he000, enc_clwsp(5'd0, 8'h10)};
    imem[33] = mk_addi(5'd6, 12'h042);
    redirect(32'h80);
    expect_instr(32'h80, '0, 1'b1, 1'b1, 1'b0);
    expect_instr(32'h82, '0, 1'b1, 1'b1, 1'b0);
    expect_instr(32'h84, imem[33], 1'b0, 1'b0, 1'b1);
    wait_drain("illegal detection");
  endtask

  task automatic test_back_pressure();
    for (int k = 0; k < 8; k++) begin
      imem[64 + k] = mk_addi(5'(k + 16), 12'(k * 3 + 1));
    end
    redirect(32'h100);
    for (int k = 0; k < 8; k++) begin
      expect_instr(addr_t'(32'h100 + 4 * k), imem[64 + k], 1'b0, 1'b0, 1'b1);
    end
    for (int n = 0; n < 20; n++) begin
      instr_ready_i = lfsr_bits(1);
      next_cycle();
    end
    instr_ready_i = 1'b1;
    wait_drain("back-pressure stream");
  endtask

  // redirect into the middle of a word while the old stream is in flight
  task automatic test_redirect();
    redirect(32'h180);
    expect_instr(32'h180, imem[96], 1'b0, 1'b0, 1'b1);
    wait_drain("stream before redirect");
    redirect(32'h66);
    test_mixed_alignment(1'b0);
    wait_drain("redirect target");
  endtask

  initial begin
    // fill depends on the whole word address
    for (int i = 0; i < 128; i++) begin
      imem[i] = {i[29:0], 2'b11} ^ 32'h5a00_0000;
    end
    rst_n_i       = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    mem_rvalid_i  = 1'b0;
    mem_rdata_i   = '0;
    instr_ready_i = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    test_plain_stream();
    test_compressed();
    test_mixed_alignment(1'b1);
    wait_drain("mixed alignment");
    test_illegal();
    test_back_pressure();
    test_redirect();
    repeat (4) next_cycle();
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
